// ==== flist.f ====
+incdir+.
displayPkg.sv
motionPkg.sv
jumpTickTimer.sv
jumpCtrl.sv
posAxisX.sv
posAxisY.sv
objPosGen.sv
tbObjPos.sv

// ==== runSim.sh ====
#!/bin/sh
set -e

# build the testbench and the design into obj_dir
verilator --binary --timing -Wno-fatal -f flist.f --top-module tbObjPos -o simObjPos

out=$(./obj_dir/simObjPos)
echo "$out"
if echo "$out" | grep -q "Simulation completed successfully"
then
	exit 0
fi
exit 1

// ==== tbObjPos.sv ====
module tbObjPos;

	import displayPkg::*;
	import motionPkg::*;

	// model of everything that advances once per frame
	typedef struct packed {
		objBox    box;
		jumpState state;
		vCoord    speed;
		vCoord    budget;       // height left for the rise
		tickCount count;        // frames since last speed change
	} frameModel;

	logic     iCLK;
	logic     iRST;
	logic     frameEnd;
	moveCmd   cmd;
	objGeom   geom;
	stepCfg   step;
	jumpCfg   jump;
	hSize     hDisplay;
	vSize     vDisplay;
	objBox    box;
	wallFlags walls;
	logic     airborne;

	frameModel model;           // expected state after the last frame
	string     testName;
	integer    seed;
	int        errors;
	int        checks;

	objPosGen UUT (
		.iCLK     (iCLK),
		.iRST     (iRST),
		.frameEnd (frameEnd),
		.cmd      (cmd),
		.geom     (geom),
		.step     (step),
		.jump     (jump),
		.hDisplay (hDisplay),
		.vDisplay (vDisplay),
		.box      (box),
		.walls    (walls),
		.airborne (airborne)
	);

	initial
	begin
		iCLK = 1'b0;
		forever #5 iCLK = ~iCLK;
	end

	//----------------------------------------------------------------------
	// reference model
	//----------------------------------------------------------------------
	function automatic frameModel resetModel();
		frameModel m;
		m.box.left   = geom.initX;
		m.box.right  = geom.initX + hCoord'(geom.sizeX);
		m.box.top    = geom.initY;
		m.box.bottom = geom.initY + vCoord'(geom.sizeY);
		m.state      = jumpIdle;
		m.speed      = jump.startSpeed;
		m.budget     = jump.peak;
		m.count      = '0;
		return m;
	endfunction

	function automatic wallFlags wallsOf(objBox b);
		wallFlags w;
		w.atLeft  = (b.left == '0);
		w.atRight = (b.right == hCoord'(hDisplay));
		return w;
	endfunction

	// one frame end with command c
	function automatic frameModel nextFrame(frameModel m, moveCmd c);
		frameModel n;
		hCoord     hStep;
		hCoord     wall;
		vCoord     floorY;
		vCoord     yStep;
		logic      tick;
		logic      landed;
		n      = m;
		wall   = hCoord'(hDisplay);
		floorY = vCoord'(vDisplay);
		yStep  = vCoord'(step.basic);
		hStep  = c.dash ? hCoord'(step.dash) : hCoord'(step.basic);
		tick   = (m.count == jump.period);
		landed = (m.state == jumpFall) && (m.box.bottom + m.speed >= floorY);
		// x: exactly one direction, then clamp to the walls
		if (c.left != c.right)
		begin
			if (c.left)
			begin
				hStep = -hStep;
			end
			n.box.left  = m.box.left + hStep;
			n.box.right = m.box.right + hStep;
			if (n.box.right > wall)
			begin
				n.box.right = wall;
				n.box.left  = wall - hCoord'(geom.sizeX);
			end
			else if (n.box.left < 0)
			begin
				n.box.left  = '0;
				n.box.right = hCoord'(geom.sizeX);
			end
		end
		// y and jump phase, all from the old state
		case (m.state)
			jumpIdle:
			begin
				if (c.up != c.down)
				begin
					n.box.top    = c.up ? m.box.top - yStep : m.box.top + yStep;
					n.box.bottom = c.up ? m.box.bottom - yStep : m.box.bottom + yStep;
				end
				n.speed  = jump.startSpeed;
				n.budget = jump.peak;
				if (c.jump)
				begin
					n.state = jumpRise;
				end
			end
			jumpRise:
			begin
				n.box.top    = m.box.top - m.speed;    // rising is negative y
				n.box.bottom = m.box.bottom - m.speed;
				if (!c.jump)
				begin
					n.state = jumpFall;
				end
				else
				begin
					n.budget = m.budget - m.speed;
					if (n.budget < 0)
					begin
						n.state = jumpFall;
					end
				end
				if (tick && m.speed != vCoord'(jump.speedMin))
				begin
					n.speed = m.speed - vCoord'(1);
				end
			end
			default:
			begin
				if (m.box.bottom + m.speed > floorY)
				begin
					n.box.top    = geom.initY;      // would pass the floor
					n.box.bottom = geom.initY + vCoord'(geom.sizeY);
				end
				else
				begin
					n.box.top    = m.box.top + m.speed;
					n.box.bottom = m.box.bottom + m.speed;
				end
				if (landed)
				begin
					n.state = jumpIdle;
				end
				if (tick && m.speed != vCoord'(jump.speedMax))
				begin
					n.speed = m.speed + vCoord'(1);
				end
			end
		endcase
		// frame counter, zero on the ground
		if (m.state == jumpIdle || n.state == jumpIdle || tick)
		begin
			n.count = '0;
		end
		else
		begin
			n.count = m.count + tickCount'(1);
		end
		return n;
	endfunction

	//----------------------------------------------------------------------
	// compare tasks
	//----------------------------------------------------------------------
	task automatic checkBox(string name, objBox e, objBox a);
		checks++;
		if (a !== e)
		begin
			errors++;
			$display("[ERROR] %s: box expected %0d %0d %0d %0d, actual %0d %0d %0d %0d", name,
				e.left, e.right, e.top, e.bottom, a.left, a.right, a.top, a.bottom);
		end
	endtask

	task automatic checkWalls(string name, wallFlags e, wallFlags a);
		checks++;
		if (a !== e)
		begin
			errors++;
			$display("[ERROR] %s: walls expected %b, actual %b", name, e, a);
		end
	endtask

	task automatic checkFlag(string name, logic e, logic a);
		checks++;
		if (a !== e)
		begin
			errors++;
			$display("[ERROR] %s: airborne expected %b, actual %b", name, e, a);
		end
	endtask

	task automatic abortRun(string why);
		$display("%s", why);
		$display("Simulation failed");
		$finish;
	endtask

	//----------------------------------------------------------------------
	// stimulus helpers
	//----------------------------------------------------------------------
	function automatic moveCmd makeCmd(logic l, logic r, logic u, logic d, logic s, logic j);
		return {l, r, u, d, s, j};
	endfunction

	// called just after a rising edge, returns one frame (4 cycles) later
	task automatic runFrame(moveCmd c);
		wallFlags lagWalls;
		lagWalls = wallsOf(model.box);
		cmd      = c;
		frameEnd = 1'b1;
		model    = nextFrame(model, c);
		@(posedge iCLK);
		#1;
		frameEnd = 1'b0;
		checkWalls({testName, " lag"}, lagWalls, walls);    // box moved, walls not yet
		repeat (3)
		begin
			@(posedge iCLK);
			#1;
		end
	endtask

	task automatic resetDut();
		iRST     = 1'b1;
		frameEnd = 1'b0;
		cmd      = '0;
		repeat (5) @(posedge iCLK);
		#1;
		iRST  = 1'b0;
		model = resetModel();
		checkBox("reset", model.box, box);
		checkWalls("reset", '0, walls);
		checkFlag("reset", 1'b0, airborne);
	endtask

	// hold c until the jump is over
	task automatic jumpToGround(moveCmd c);
		int n;
		n = 0;
		while (airborne && n < 300)
		begin
			runFrame(c);
			n++;
		end
		if (airborne)
		begin
			abortRun("jump did not end within 300 frames");
		end
	endtask

	//----------------------------------------------------------------------
	// compare process, two cycles after each frame end
	//----------------------------------------------------------------------
	initial
	begin : compareProc
		int idle;
		forever
		begin
			idle = 0;
			@(posedge iCLK);
			while (!frameEnd)
			begin
				idle++;
				if (idle > 50)
				begin
					abortRun("no frame end pulse for 50 cycles");
				end
				@(posedge iCLK);
			end
			@(posedge iCLK);
			#2;
			checkBox(testName, model.box, box);
			checkFlag(testName, model.state != jumpIdle, airborne);
			checkWalls(testName, wallsOf(model.box), walls);
		end
	end

	//----------------------------------------------------------------------
	// test sequence
	//----------------------------------------------------------------------
	initial
	begin : mainFlow
		int          n;
		logic [31:0] rnd;
		seed              = 32'he3a3;
		errors            = 0;
		checks            = 0;
		testName          = "reset";
		iRST              = 1'b1;
		frameEnd          = 1'b0;
		cmd               = '0;
		geom.initX        = hCoord'(300);
		geom.initY        = vCoord'(400);
		geom.sizeX        = hSize'(32);
		geom.sizeY        = vSize'(40);
		step.basic        = basicGain'(3);
		step.dash         = dashGain'(12);
		jump.peak         = vCoord'(60);
		jump.startSpeed   = vCoord'(8);
		jump.speedMax     = gyroSpeed'(7);
		jump.speedMin     = gyroSpeed'(1);
		jump.period       = tickCount'(0);
		hDisplay          = hSize'(640);
		vDisplay          = vSize'(480);
		resetDut();

		// mid screen, so a move either way would show
		testName = "both held";
		repeat (3) runFrame(makeCmd(1, 1, 0, 0, 1, 0));

		// walk into each wall, basic then dash
		testName = "right basic";
		n = 0;
		while (!walls.atRight && n < 400)
		begin
			runFrame(makeCmd(0, 1, 0, 0, 0, 0));
			n++;
		end
		if (!walls.atRight)
		begin
			abortRun("right wall not reached with the basic step");
		end
		runFrame(makeCmd(0, 1, 0, 0, 0, 0));                // push against the wall
		testName = "left dash";
		n = 0;
		while (!walls.atLeft && n < 400)
		begin
			runFrame(makeCmd(1, 0, 0, 0, 1, 0));
			n++;
		end
		if (!walls.atLeft)
		begin
			abortRun("left wall not reached with the dash step");
		end
		testName = "right dash";
		n = 0;
		while (!walls.atRight && n < 400)
		begin
			runFrame(makeCmd(0, 1, 0, 0, 1, 0));
			n++;
		end
		if (!walls.atRight)
		begin
			abortRun("right wall not reached with the dash step");
		end
		testName = "left basic";
		n = 0;
		while (!walls.atLeft && n < 400)
		begin
			runFrame(makeCmd(1, 0, 0, 0, 0, 0));
			n++;
		end
		if (!walls.atLeft)
		begin
			abortRun("left wall not reached with the basic step");
		end

		// up past the top edge into negative y
		testName = "idle up";
		n = 0;
		while (box.top >= 0 && n < 300)
		begin
			runFrame(makeCmd(0, 0, 1, 0, 0, 0));
			n++;
		end
		if (box.top >= 0)
		begin
			abortRun("box never reached negative y");
		end
		testName = "idle down";
		repeat (5) runFrame(makeCmd(0, 0, 0, 1, 0, 0));
		runFrame(makeCmd(0, 0, 1, 1, 0, 0));

		// full jumps, speed change every frame then every third
		testName = "jump period 0";
		resetDut();
		runFrame(makeCmd(0, 0, 0, 0, 0, 1));
		jumpToGround(makeCmd(0, 0, 0, 0, 0, 1));
		testName = "jump period 2";
		jump.period = tickCount'(2);
		resetDut();
		runFrame(makeCmd(0, 0, 0, 0, 0, 1));
		jumpToGround(makeCmd(0, 0, 0, 0, 0, 1));

		testName = "jump release";
		resetDut();
		repeat (3) runFrame(makeCmd(0, 1, 0, 0, 0, 1));
		jumpToGround(makeCmd(0, 1, 0, 0, 0, 0));            // release mid-rise

		testName = "random";
		repeat (200)
		begin
			rnd = $random(seed);
			runFrame(moveCmd'(rnd[5:0]));
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
		begin
			$display("Simulation completed successfully");
		end
		else
		begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== objPosGen.sv ====
module objPosGen
(
	input  logic                 iCLK,
	input  logic                 iRST,
	input  logic                 frameEnd,   // from the video timing
	input  motionPkg::moveCmd    cmd,
	input  displayPkg::objGeom   geom,
	input  motionPkg::stepCfg    step,
	input  motionPkg::jumpCfg    jump,
	input  displayPkg::hSize     hDisplay,
	input  displayPkg::vSize     vDisplay,
	output displayPkg::objBox    box,
	output displayPkg::wallFlags walls,
	output logic                 airborne
);

	import displayPkg::*;
	import motionPkg::*;

	//----------------------------------------------------------------------
	// internal links
	//----------------------------------------------------------------------
	jumpState jState;           // FSM phase
	vCoord    jSpeed;           // jump step
	logic     jTick;            // speed update frame
	logic     landed;
	hCoord    boxLeft;
	hCoord    boxRight;
	vCoord    boxTop;
	vCoord    boxBottom;

	assign box = '{left: boxLeft, right: boxRight, top: boxTop, bottom: boxBottom};

	//----------------------------------------------------------------------
	// jump path
	//----------------------------------------------------------------------
	jumpTickTimer uTimer (
		.iCLK     (iCLK),
		.iRST     (iRST),
		.frameEnd (frameEnd),
		.state    (jState),
		.period   (jump.period),
		.jumpTick (jTick)
	);

	jumpCtrl uJump (
		.iCLK     (iCLK),
		.iRST     (iRST),
		.frameEnd (frameEnd),
		.cmd      (cmd),
		.cfg      (jump),
		.jumpTick (jTick),
		.landed   (landed),
		.state    (jState),
		.speed    (jSpeed),
		.airborne (airborne)
	);

	//----------------------------------------------------------------------
	// axes
	//----------------------------------------------------------------------
	posAxisX uAxisX (
		.iCLK     (iCLK),
		.iRST     (iRST),
		.frameEnd (frameEnd),
		.cmd      (cmd),
		.geom     (geom),
		.step     (step),
		.hDisplay (hDisplay),
		.left     (boxLeft),
		.right    (boxRight),
		.walls    (walls)
	);

	posAxisY uAxisY (
		.iCLK     (iCLK),
		.iRST     (iRST),
		.frameEnd (frameEnd),
		.cmd      (cmd),
		.geom     (geom),
		.basic    (step.basic),     // y walks with the x basic step
		.vDisplay (vDisplay),
		.state    (jState),
		.speed    (jSpeed),
		.top      (boxTop),
		.bottom   (boxBottom),
		.landed   (landed)
	);

endmodule

// ==== posAxisY.sv ====
module posAxisY
(
	input  logic                iCLK,
	input  logic                iRST,
	input  logic                frameEnd,
	input  motionPkg::moveCmd   cmd,
	input  displayPkg::objGeom  geom,
	input  motionPkg::basicGain basic,      // idle up/down step
	input  displayPkg::vSize    vDisplay,   // screen height, the floor
	input  motionPkg::jumpState state,
	input  displayPkg::vCoord   speed,      // jump step from the FSM
	output displayPkg::vCoord   top,
	output displayPkg::vCoord   bottom,
	output logic                landed
);

	import displayPkg::*;
	import motionPkg::*;

	//----------------------------------------------------------------------
	// start position and steps
	//----------------------------------------------------------------------
	vCoord sizeY;
	vCoord initBottom;          // bottom edge after reset
	vCoord floorY;              // screen height as a signed coordinate
	vCoord basicStep;
	vCoord fallTop;
	vCoord fallBottom;          // bottom after a fall step
	logic  moveUp;
	logic  moveDown;

	assign sizeY      = vCoord'(geom.sizeY);
	assign initBottom = geom.initY + sizeY;
	assign floorY     = vCoord'(vDisplay);
	assign basicStep  = vCoord'(basic);         // sign extended
	assign fallTop    = top + speed;
	assign fallBottom = bottom + speed;

	assign moveUp     = cmd.up && !cmd.down;
	assign moveDown   = cmd.down && !cmd.up;

	// reaches or passes the floor on the next fall step
	assign landed = (state == jumpFall) && (fallBottom >= floorY);

	//----------------------------------------------------------------------
	// edge registers
	//----------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			top    <= geom.initY;
			bottom <= initBottom;
		end
		else if (frameEnd)
		begin
			case (state)
				jumpIdle:
				begin
					// free move, may leave the screen
					if (moveUp)
					begin
						top    <= top - basicStep;
						bottom <= bottom - basicStep;
					end
					else if (moveDown)
					begin
						top    <= top + basicStep;
						bottom <= bottom + basicStep;
					end
				end
				jumpRise:
				begin
					top    <= top - speed;      // y grows downward
					bottom <= bottom - speed;
				end
				jumpFall:
				begin
					if (fallBottom > floorY)
					begin
						top    <= geom.initY;   // overshoot, back to start
						bottom <= initBottom;
					end
					else
					begin
						top    <= fallTop;
						bottom <= fallBottom;
					end
				end
				default:
				begin
					top    <= top;
					bottom <= bottom;
				end
			endcase
		end
	end

endmodule

// ==== posAxisX.sv ====
module posAxisX
(
	input  logic                iCLK,
	input  logic                iRST,
	input  logic                frameEnd,
	input  motionPkg::moveCmd   cmd,
	input  displayPkg::objGeom  geom,
	input  motionPkg::stepCfg   step,
	input  displayPkg::hSize    hDisplay,   // screen width
	output displayPkg::hCoord   left,
	output displayPkg::hCoord   right,
	output displayPkg::wallFlags walls
);

	import displayPkg::*;
	import motionPkg::*;

	//----------------------------------------------------------------------
	// widened inputs
	//----------------------------------------------------------------------
	hCoord    sizeX;            // width as a signed coordinate
	hCoord    wallRight;        // screen width as a signed coordinate
	basicGain basicStep;
	dashGain  dashStep;
	hCoord    stepSel;          // step used this frame
	hCoord    nextLeft;
	hCoord    nextRight;
	logic     moveLeft;
	logic     moveRight;

	assign sizeX     = hCoord'(geom.sizeX);         // zero extended
	assign wallRight = hCoord'(hDisplay);
	assign basicStep = step.basic;
	assign dashStep  = step.dash;
	assign stepSel   = cmd.dash ? hCoord'(dashStep) : hCoord'(basicStep);

	// both held cancels out
	assign moveLeft  = cmd.left && !cmd.right;
	assign moveRight = cmd.right && !cmd.left;

	assign nextLeft  = moveLeft ? left - stepSel : left + stepSel;
	assign nextRight = moveLeft ? right - stepSel : right + stepSel;

	//----------------------------------------------------------------------
	// edge registers
	//----------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			left  <= geom.initX;
			right <= geom.initX + sizeX;
		end
		else if (frameEnd && (moveLeft || moveRight))
		begin
			if (nextRight > wallRight)
			begin
				right <= wallRight;             // stop on the right wall
				left  <= wallRight - sizeX;
			end
			else if (nextLeft < 0)
			begin
				left  <= '0;                    // stop on the left wall
				right <= sizeX;
			end
			else
			begin
				left  <= nextLeft;
				right <= nextRight;
			end
		end
	end

	//----------------------------------------------------------------------
	// wall contact
	//----------------------------------------------------------------------
	// follows the box one cycle late
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			walls <= '0;
		end
		else
		begin
			walls.atLeft  <= (left == '0);
			walls.atRight <= (right == wallRight);
		end
	end

endmodule

// ==== jumpCtrl.sv ====
module jumpCtrl
(
	input  logic                iCLK,
	input  logic                iRST,
	input  logic                frameEnd,
	input  motionPkg::moveCmd   cmd,        // only jump is used here
	input  motionPkg::jumpCfg   cfg,
	input  logic                jumpTick,   // speed update frame
	input  logic                landed,     // next fall step hits the floor
	output motionPkg::jumpState state,
	output displayPkg::vCoord   speed,      // vertical step per frame
	output logic                airborne
);

	import displayPkg::*;
	import motionPkg::*;

	//----------------------------------------------------------------------
	// height budget and speed limits
	//----------------------------------------------------------------------
	vCoord    budget;       // height still left for the rise
	vCoord    budgetNext;
	gyroSpeed minSpeed;
	gyroSpeed maxSpeed;
	logic     atMin;
	logic     atMax;

	assign budgetNext = budget - speed;     // after this frame's rise
	assign minSpeed   = cfg.speedMin;
	assign maxSpeed   = cfg.speedMax;
	assign atMin      = (speed == vCoord'(minSpeed));  // sign extended
	assign atMax      = (speed == vCoord'(maxSpeed));

	//----------------------------------------------------------------------
	// jump FSM
	//----------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state  <= jumpIdle;
			speed  <= cfg.startSpeed;
			budget <= cfg.peak;
		end
		else if (frameEnd)
		begin
			case (state)
				jumpIdle:
				begin
					speed  <= cfg.startSpeed;       // ready for the next takeoff
					budget <= cfg.peak;
					if (cmd.jump)
					begin
						state <= jumpRise;
					end
				end
				jumpRise:
				begin
					if (!cmd.jump)
					begin
						state <= jumpFall;          // early release cuts the rise
					end
					else
					begin
						budget <= budgetNext;
						if (budgetNext < 0)
						begin
							state <= jumpFall;      // budget spent, top reached
						end
					end
					// rise slows down toward speedMin
					if (jumpTick && !atMin)
					begin
						speed <= speed - 1'b1;
					end
				end
				jumpFall:
				begin
					if (landed)
					begin
						state <= jumpIdle;
					end
					// fall speeds up toward speedMax
					if (jumpTick && !atMax)
					begin
						speed <= speed + 1'b1;
					end
				end
				default:
				begin
					state <= jumpIdle;
				end
			endcase
		end
	end

	// anything but idle counts as in the air
	assign airborne = (state != jumpIdle);

endmodule

// ==== jumpTickTimer.sv ====
module jumpTickTimer
(
	input  logic                iCLK,
	input  logic                iRST,
	input  logic                frameEnd,   // one cycle per frame
	input  motionPkg::jumpState state,      // jump phase from the FSM
	input  motionPkg::tickCount period,     // wrap value of the count
	output logic                jumpTick    // speed update frame
);

	import motionPkg::*;

	//----------------------------------------------------------------------
	// frame counter during a jump
	//----------------------------------------------------------------------
	tickCount count;

	// held at zero on the ground so every jump starts aligned
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			count <= '0;
		end
		else if (state == jumpIdle)
		begin
			count <= '0;
		end
		else if (frameEnd)
		begin
			if (jumpTick)
			begin
				count <= '0;            // wrap on the update frame
			end
			else
			begin
				count <= count + 1'b1;
			end
		end
	end

	//----------------------------------------------------------------------
	// tick output
	//----------------------------------------------------------------------
	// period 0 gives a tick on every frame of the jump
	// period n gives one on every (n+1)-th frame
	assign jumpTick = (count == period);

endmodule

// ==== motionPkg.sv ====
`include "objPos_macros.svh"

package motionPkg;

	//----------------------------------------------------------------------
	// speed and step types
	//----------------------------------------------------------------------
	typedef logic signed [`OBJ_BASIC_GAIN_W:0] basicGain;  // walk step
	typedef logic signed [`OBJ_DASH_GAIN_W:0]  dashGain;   // dash step
	typedef logic signed [`OBJ_GYRO_W:0]       gyroSpeed;  // jump speed bound
	typedef logic        [`OBJ_TICK_W-1:0]     tickCount;  // frame counter

	//----------------------------------------------------------------------
	// player command levels, sampled on frame end
	//----------------------------------------------------------------------
	typedef struct packed {
		logic left;
		logic right;
		logic up;
		logic down;
		logic dash;         // swaps basic step for dash step in x
		logic jump;         // hold to keep rising
	} moveCmd;

	// jump shape
	typedef struct packed {
		displayPkg::vCoord peak;        // height budget for the rise
		displayPkg::vCoord startSpeed;  // first rise step
		gyroSpeed          speedMax;    // fall speed stops here
		gyroSpeed          speedMin;    // rise speed stops here
		tickCount          period;      // frames between speed changes, minus one
	} jumpCfg;

	// horizontal steps
	typedef struct packed {
		basicGain basic;
		dashGain  dash;
	} stepCfg;

	typedef enum logic [1:0] {jumpIdle, jumpRise, jumpFall} jumpState;

endpackage

// ==== displayPkg.sv ====
`include "objPos_macros.svh"

package displayPkg;

	//----------------------------------------------------------------------
	// screen coordinates
	//----------------------------------------------------------------------
	// one extra bit so the box can sit off screen on the negative side
	typedef logic signed [`OBJ_H_WIDTH:0]   hCoord;     // x position
	typedef logic signed [`OBJ_V_WIDTH:0]   vCoord;     // y position
	typedef logic        [`OBJ_H_WIDTH-1:0] hSize;      // width, never negative
	typedef logic        [`OBJ_V_WIDTH-1:0] vSize;      // height, never negative

	//----------------------------------------------------------------------
	// sprite geometry
	//----------------------------------------------------------------------
	typedef struct packed {
		hCoord left;        // x of left edge
		hCoord right;       // x of right edge
		vCoord top;         // y of top edge
		vCoord bottom;      // y of bottom edge, grows downward
	} objBox;

	// wall contact, registered in the x axis
	typedef struct packed {
		logic atLeft;       // left edge on x = 0
		logic atRight;      // right edge on screen width
	} wallFlags;

	// start position and size, held constant while running
	typedef struct packed {
		hCoord initX;
		vCoord initY;
		hSize  sizeX;
		vSize  sizeY;
	} objGeom;

endpackage

// ==== objPos_macros.svh ====
`ifndef OBJPOS_MACROS_SVH
`define OBJPOS_MACROS_SVH

//----------------------------------------------------------------------
// screen size widths
//----------------------------------------------------------------------
`define OBJ_H_WIDTH         11      // unsigned screen width bits
`define OBJ_V_WIDTH         11      // unsigned screen height bits

//----------------------------------------------------------------------
// motion magnitudes
//----------------------------------------------------------------------
// each step type adds one sign bit on top of these
`define OBJ_BASIC_GAIN_W    3       // basic step magnitude
`define OBJ_DASH_GAIN_W     4       // dash step magnitude
`define OBJ_GYRO_W          4       // jump speed limit magnitude

// frames per jump speed change, up to 64
`define OBJ_TICK_W          6

`endif
